/* rtl/cpu_start_pkg.sv */
`default_nettype none

package cpu_start_pkg;

  // bus widths
  localparam int addr_w = 16;
  localparam int data_w = 32;

  typedef logic [addr_w-1:0] addr_t;
  typedef logic [data_w-1:0] word_t;

  // word holding the context base
  localparam addr_t boot_addr = addr_t'(0);

  // instruction pointer slot, relative to the base
  localparam addr_t reg_ip = addr_t'(4);

  // start cycle of one command
  typedef enum logic [2:0] {
    st_begin,
    st_read_ip,
    st_read_cmd,
    st_preexec,
    st_write_ip,
    st_execute
  } start_state_t;

  typedef enum logic [1:0] {
    op_idle,
    op_read,
    op_write
  } bus_op_t;

  // one-cycle request pulse, op idle when nothing is asked
  typedef struct packed {
    bus_op_t op;
    addr_t   addr;
    word_t   wdata;
  } bus_req_t;

  // done pulse, rdata valid with it on reads
  typedef struct packed {
    logic  done;
    word_t rdata;
  } bus_rsp_t;

endpackage

`default_nettype wire

/* rtl/start_sequencer.sv */
`timescale 1ns/1ps
`default_nettype none

module start_sequencer (
  input  wire                         clk,
  input  wire                         rst,
  input  wire logic                   advance,
  input  wire logic                   exec_done,
  output cpu_start_pkg::start_state_t state
);
  import cpu_start_pkg::*;

  start_state_t state_q;
  start_state_t state_d;

  always_comb begin
    state_d = state_q;
    unique case (state_q)
      st_begin: begin
        if (advance) state_d = st_read_ip;
      end
      st_read_ip: begin
        if (advance) state_d = st_read_cmd;
      end
      st_read_cmd: begin
        if (advance) state_d = st_preexec;
      end
      // single cycle, pointer bumps here
      st_preexec: begin
        state_d = st_write_ip;
      end
      st_write_ip: begin
        if (advance) state_d = st_execute;
      end
      st_execute: begin
        if (exec_done) state_d = st_read_ip;
      end
      default: begin
        state_d = st_begin;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q <= st_begin;
    end else begin
      state_q <= state_d;
    end
  end

  assign state = state_q;

  // manager only advances out of bus states
  a_no_advance_off_bus: assert property (
    @(posedge clk) disable iff (rst)
    advance |-> !(state_q inside {st_preexec, st_execute})
  );

endmodule

`default_nettype wire

/* rtl/start_manager.sv */
`timescale 1ns/1ps
`default_nettype none

module start_manager (
  input  wire                         clk,
  input  wire                         rst,
  input  cpu_start_pkg::start_state_t state,
  input  wire logic                   mgr_grant,
  output cpu_start_pkg::bus_req_t     req,
  input  cpu_start_pkg::bus_rsp_t     rsp,
  output logic                        advance,
  output cpu_start_pkg::word_t        command,
  output logic                        cmd_valid
);
  import cpu_start_pkg::*;

  addr_t base_addr;
  addr_t ip;
  word_t command_q;
  logic  issued;
  logic  bus_state;
  logic  issue;
  addr_t ip_addr;

  // register slot of the instruction pointer
  assign ip_addr = base_addr + reg_ip;

  assign bus_state = state inside {st_begin, st_read_ip, st_read_cmd, st_write_ip};

  // one request per bus state, as soon as the bus is ours
  assign issue = bus_state && !issued && mgr_grant;

  always_comb begin
    req.op    = op_idle;
    req.addr  = '0;
    req.wdata = '0;
    if (issue) begin
      unique case (state)
        st_begin: begin
          req.op   = op_read;
          req.addr = boot_addr;
        end
        st_read_ip: begin
          req.op   = op_read;
          req.addr = ip_addr;
        end
        st_read_cmd: begin
          req.op   = op_read;
          req.addr = ip;
        end
        st_write_ip: begin
          req.op    = op_write;
          req.addr  = ip_addr;
          req.wdata = {{(data_w - addr_w){1'b0}}, ip};
        end
        default: begin
          req.op = op_idle;
        end
      endcase
    end
  end

  // done closes the transaction of this state
  assign advance = rsp.done && issued;

  always_ff @(posedge clk) begin
    if (rst) begin
      issued <= 1'b0;
    end else if (advance) begin
      issued <= 1'b0;
    end else if (issue) begin
      issued <= 1'b1;
    end
  end

  // base, pointer and command capture
  always_ff @(posedge clk) begin
    if (advance && state == st_begin) begin
      base_addr <= rsp.rdata[addr_w-1:0];
    end
    if (advance && state == st_read_ip) begin
      ip <= rsp.rdata[addr_w-1:0];
    end else if (state == st_preexec) begin
      ip <= ip + addr_t'(1);
    end
    if (advance && state == st_read_cmd) begin
      command_q <= rsp.rdata;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      cmd_valid <= 1'b0;
    end else begin
      cmd_valid <= (state == st_execute);
    end
  end

  assign command = command_q;

  // memory answers exactly one cycle later, nothing new meanwhile
  a_one_outstanding: assert property (
    @(posedge clk) disable iff (rst)
    req.op != op_idle |=> rsp.done && req.op == op_idle
  );

  // dispatcher must not hand us a foreign done
  a_done_is_ours: assert property (
    @(posedge clk) disable iff (rst)
    rsp.done |-> $past(req.op != op_idle)
  );

endmodule

`default_nettype wire

/* rtl/bus_dispatcher.sv */
`timescale 1ns/1ps
`default_nettype none

module bus_dispatcher (
  input  wire                     clk,
  input  wire                     rst,
  input  cpu_start_pkg::bus_req_t host_req,
  output cpu_start_pkg::bus_rsp_t host_rsp,
  output logic                    host_grant,
  input  cpu_start_pkg::bus_req_t mgr_req,
  output cpu_start_pkg::bus_rsp_t mgr_rsp,
  output logic                    mgr_grant,
  output cpu_start_pkg::bus_req_t mem_req,
  input  cpu_start_pkg::bus_rsp_t mem_rsp
);
  import cpu_start_pkg::*;

  // owner of the transaction in flight
  logic host_busy;
  logic mgr_busy;
  logic host_fwd;
  logic mgr_fwd;

  // a transaction ending this cycle no longer blocks the other side
  assign host_grant = !(mgr_busy && !mem_rsp.done);
  assign mgr_grant  = (host_req.op == op_idle) && !(host_busy && !mem_rsp.done);

  // host pulses without grant are dropped
  assign host_fwd = (host_req.op != op_idle) && host_grant;
  assign mgr_fwd  = (mgr_req.op != op_idle);

  always_comb begin
    if (host_fwd) begin
      mem_req = host_req;
    end else if (mgr_fwd) begin
      mem_req = mgr_req;
    end else begin
      mem_req.op    = op_idle;
      mem_req.addr  = '0;
      mem_req.wdata = '0;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      host_busy <= 1'b0;
      mgr_busy  <= 1'b0;
    end else begin
      host_busy <= host_fwd || (host_busy && !mem_rsp.done);
      mgr_busy  <= (mgr_fwd && !host_fwd) || (mgr_busy && !mem_rsp.done);
    end
  end

  // done goes back only to the owner
  assign host_rsp.done  = mem_rsp.done && host_busy;
  assign host_rsp.rdata = mem_rsp.rdata;
  assign mgr_rsp.done   = mem_rsp.done && mgr_busy;
  assign mgr_rsp.rdata  = mem_rsp.rdata;

  // manager has to respect mgr_grant
  a_single_forward: assert property (
    @(posedge clk) disable iff (rst)
    !(host_fwd && mgr_fwd)
  );

endmodule

`default_nettype wire

/* rtl/word_memory.sv */
`timescale 1ns/1ps
`default_nettype none

module word_memory #(
  parameter int mem_words = 1024
) (
  input  wire                     clk,
  input  wire                     rst,
  input  cpu_start_pkg::bus_req_t req,
  output cpu_start_pkg::bus_rsp_t rsp
);
  import cpu_start_pkg::*;

  localparam int idx_w = $clog2(mem_words);

  word_t             mem [mem_words];
  logic  [idx_w-1:0] idx;
  logic              done_q;
  word_t             rdata_q;

  // address wraps around the depth
  assign idx = idx_w'(req.addr % mem_words);

  always_ff @(posedge clk) begin
    if (req.op == op_write) begin
      mem[idx] <= req.wdata;
    end
    if (req.op == op_read) begin
      rdata_q <= mem[idx];
    end
  end

  // writes are acknowledged too
  always_ff @(posedge clk) begin
    if (rst) begin
      done_q <= 1'b0;
    end else begin
      done_q <= (req.op != op_idle);
    end
  end

  assign rsp.done  = done_q;
  assign rsp.rdata = rdata_q;

endmodule

`default_nettype wire

/* rtl/cpu_front_top.sv */
`timescale 1ns/1ps
`default_nettype none

module cpu_front_top #(
  parameter int mem_words = 1024
) (
  input  wire                         clk,
  input  wire                         rst,
  input  cpu_start_pkg::bus_req_t     host_req,
  output cpu_start_pkg::bus_rsp_t     host_rsp,
  output logic                        host_grant,
  input  wire logic                   exec_done,
  output cpu_start_pkg::word_t        command,
  output logic                        cmd_valid,
  output cpu_start_pkg::start_state_t state
);
  import cpu_start_pkg::*;

  logic     advance;
  logic     mgr_grant;
  bus_req_t mgr_req;
  bus_rsp_t mgr_rsp;
  bus_req_t mem_req;
  bus_rsp_t mem_rsp;

  start_sequencer start_sequencer_inst (
    .clk       (clk),
    .rst       (rst),
    .advance   (advance),
    .exec_done (exec_done),
    .state     (state)
  );

  start_manager start_manager_inst (
    .clk       (clk),
    .rst       (rst),
    .state     (state),
    .mgr_grant (mgr_grant),
    .req       (mgr_req),
    .rsp       (mgr_rsp),
    .advance   (advance),
    .command   (command),
    .cmd_valid (cmd_valid)
  );

  // host port and front end share one memory
  bus_dispatcher bus_dispatcher_inst (
    .clk        (clk),
    .rst        (rst),
    .host_req   (host_req),
    .host_rsp   (host_rsp),
    .host_grant (host_grant),
    .mgr_req    (mgr_req),
    .mgr_rsp    (mgr_rsp),
    .mgr_grant  (mgr_grant),
    .mem_req    (mem_req),
    .mem_rsp    (mem_rsp)
  );

  word_memory #(
    .mem_words (mem_words)
  ) word_memory_inst (
    .clk (clk),
    .rst (rst),
    .req (mem_req),
    .rsp (mem_rsp)
  );

endmodule

`default_nettype wire

/* verification/tb_cpu_front.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_cpu_front;
  import cpu_start_pkg::*;

  localparam int mem_words    = 1024;
  localparam int prog_words   = 64;
  localparam int num_commands = 20;
  localparam int wait_limit   = 200;
  localparam bus_req_t idle_req = '{op: op_idle, addr: '0, wdata: '0};

  logic         clk;
  logic         rst;
  bus_req_t     host_req;
  bus_rsp_t     host_rsp;
  logic         host_grant;
  logic         exec_done;
  word_t        command;
  logic         cmd_valid;
  start_state_t state;

  // mirror of the shared memory
  word_t       model_mem [mem_words];
  addr_t       load_q [$];
  addr_t       base;
  addr_t       ip0;
  addr_t       probe_addr;
  word_t       exp_cmd;
  word_t       rdata;
  word_t       wdata;
  int unsigned seed;
  int unsigned value_errors;
  int unsigned timeout_errors;
  int          hold;
  int          n;
  int          i;

  cpu_front_top #(
    .mem_words (mem_words)
  ) cpu_front_top_inst (
    .clk        (clk),
    .rst        (rst),
    .host_req   (host_req),
    .host_rsp   (host_rsp),
    .host_grant (host_grant),
    .exec_done  (exec_done),
    .command    (command),
    .cmd_valid  (cmd_valid),
    .state      (state)
  );

  always #4 clk = ~clk;

  task automatic check_word(input string name, input word_t got, input word_t exp);
    if (got !== exp) begin
      $display("FAILED %s: got 0x%h, expected 0x%h", name, got, exp);
      value_errors++;
    end
  endtask

  task automatic check_state(input string name, input start_state_t got,
                             input start_state_t exp);
    if (got !== exp) begin
      $display("FAILED %s: got 0x%h, expected 0x%h", name, got, exp);
      value_errors++;
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("FAILED %s: got 0x%h, expected 0x%h", name, got, exp);
      value_errors++;
    end
  endtask

  function automatic int unsigned slot(input addr_t a);
    return a % mem_words;
  endfunction

  // model of one fetch with its pointer write-back
  task automatic predict_command(output word_t cmd);
    addr_t b;
    addr_t ptr;
    b   = model_mem[slot(boot_addr)][addr_w-1:0];
    ptr = model_mem[slot(b + reg_ip)][addr_w-1:0];
    cmd = model_mem[slot(ptr)];
    model_mem[slot(b + reg_ip)] = word_t'(addr_t'(ptr + addr_t'(1)));
  endtask

  task automatic wait_command();
    int t;
    t = 0;
    while (!(cmd_valid && state == st_execute) && t < wait_limit) begin
      @(negedge clk);
      t++;
      // front-end traffic must not reach the host port
      check_flag("host_rsp.done", host_rsp.done, 1'b0);
    end
    if (!(cmd_valid && state == st_execute)) begin
      $display("no command was handed out within %0d cycles", wait_limit);
      timeout_errors++;
    end
  endtask

  // single host transaction started on a falling edge
  task automatic host_access(input bus_op_t op, input addr_t a, input word_t wd,
                             output word_t rd);
    int t;
    t  = 0;
    rd = '0;
    while (!host_grant && t < wait_limit) begin
      @(negedge clk);
      t++;
    end
    if (!host_grant) begin
      $display("host port was not granted within %0d cycles", wait_limit);
      timeout_errors++;
      return;
    end
    host_req = '{op: op, addr: a, wdata: wd};
    @(negedge clk);
    host_req = idle_req;
    t = 0;
    while (!host_rsp.done && t < wait_limit) begin
      @(negedge clk);
      t++;
    end
    if (!host_rsp.done) begin
      $display("host access to address %h never completed", a);
      timeout_errors++;
    end
    rd = host_rsp.rdata;
  endtask

  initial begin
    seed           = $urandom(56);
    clk            = 1'b0;
    rst            = 1'b1;
    host_req       = idle_req;
    exec_done      = 1'b0;
    value_errors   = 0;
    timeout_errors = 0;
    base = addr_t'(16 + $urandom % 48);
    ip0  = addr_t'(128 + $urandom % 128);
    // only the low address bits of these words count
    model_mem[slot(boot_addr)]     = {addr_t'($urandom), base};
    model_mem[slot(base + reg_ip)] = {addr_t'($urandom), ip0};
    load_q = {boot_addr, addr_t'(base + reg_ip)};
    for (i = 0; i < prog_words; i++) begin
      model_mem[slot(ip0 + addr_t'(i))] = $urandom;
      load_q.push_back(ip0 + addr_t'(i));
    end
    repeat (8) @(posedge clk);
    // back-to-back writes keep the front end off the bus
    foreach (load_q[k]) begin
      @(negedge clk);
      rst = 1'b0;
      check_flag("host_grant", host_grant, 1'b1);
      check_state("state", state, st_begin);
      host_req = '{op: op_write, addr: load_q[k], wdata: model_mem[slot(load_q[k])]};
    end
    @(negedge clk);
    host_req = idle_req;
    for (n = 0; n < num_commands; n++) begin
      wait_command();
      if (timeout_errors != 0) break;
      predict_command(exp_cmd);
      check_word("command", command, exp_cmd);
      hold = $urandom % 16;
      repeat (hold) begin
        @(negedge clk);
        check_state("state", state, st_execute);
        check_flag("cmd_valid", cmd_valid, 1'b1);
        check_word("command", command, exp_cmd);
      end
      // pointer slot already holds the incremented value
      host_access(op_read, base + reg_ip, '0, rdata);
      check_word("host_rsp.rdata", rdata, model_mem[slot(base + reg_ip)]);
      probe_addr = ip0 + addr_t'($urandom % prog_words);
      host_access(op_read, probe_addr, '0, rdata);
      check_word("host_rsp.rdata", rdata, model_mem[slot(probe_addr)]);
      check_state("state", state, st_execute);
      check_word("command", command, exp_cmd);
      exec_done = 1'b1;
      @(negedge clk);
      exec_done = 1'b0;
      if ($urandom % 2 == 1) begin
        // patch the program past the next fetch
        probe_addr = model_mem[slot(base + reg_ip)][addr_w-1:0] + addr_t'(1 + $urandom % 4);
        wdata = $urandom;
        model_mem[slot(probe_addr)] = wdata;
        host_access(op_write, probe_addr, wdata, rdata);
      end
    end
    $display("value errors: %0d, timeouts: %0d", value_errors, timeout_errors);
    if (value_errors == 0 && timeout_errors == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* project.f */
rtl/cpu_start_pkg.sv
rtl/start_sequencer.sv
rtl/start_manager.sv
rtl/bus_dispatcher.sv
rtl/word_memory.sv
rtl/cpu_front_top.sv
verification/tb_cpu_front.sv
